//--- hw/alu_pkg.sv
// alu control definitions
// function, operand select and register mode codes of the bit-slice alu,
// and the control word the sequencer drives to it every cycle

package alu_pkg;

  // ---------------------------------------------------------
  // function and operand selects
  // ---------------------------------------------------------
  typedef enum logic [1:0] {
    fn_add    = 2'd0,          // f = r + s
    fn_sub    = 2'd1,          // f = r - s
    fn_pass_r = 2'd2           // f = r, s ignored
  } alu_fn_e;

  typedef enum logic [1:0] {
    r_zero  = 2'd0,
    r_cmd_a = 2'd1,            // operand a of the command
    r_a_shl = 2'd2             // a shifted left, q msb linked in
  } r_sel_e;

  typedef enum logic {
    s_zero  = 1'b0,
    s_cmd_b = 1'b1             // operand b of the command
  } s_sel_e;

  // ---------------------------------------------------------
  // register modes
  // ---------------------------------------------------------
  typedef enum logic [1:0] {
    q_hold   = 2'd0,           // d0 of the q mux
    q_load_f = 2'd1,           // d1, take f
    q_shl    = 2'd2,           // d2, lower neighbour, qli into bit 0
    q_ror    = 2'd3            // d3, upper neighbour, bit 0 into bit 15
  } qsel_e;

  typedef enum logic [1:0] {
    a_hold   = 2'd0,
    a_clear  = 2'd1,
    a_load_f = 2'd2,           // alu result
    a_load_r = 2'd3            // r operand, restores a after a failed trial
  } asel_e;

  typedef struct packed {
    alu_fn_e fn;
    r_sel_e  r_sel;
    s_sel_e  s_sel;
    qsel_e   qsel;
    asel_e   asel;
    logic    qli;              // link in for q shift left
  } alu_ctl_t;                 // 10 bits

endpackage

//--- hw/md_pkg.sv
// multiply/divide command bus definitions
// opcodes, data width and the command and response words
// carried over the req/ack handshake

package md_pkg;

  localparam int unsigned data_w = 16;  // fixed by the command bus

  // ---------------------------------------------------------
  // opcodes
  // ---------------------------------------------------------
  typedef enum logic [2:0] {
    op_add = 3'd0,             // q = a + b
    op_sub = 3'd1,             // q = a - b
    op_mul = 3'd2,             // a = a * b, low half
    op_div = 3'd3,             // q = a / b, a = a % b
    op_ror = 3'd4              // q = a rotated right by b[3:0]
  } md_op_e;

  // ---------------------------------------------------------
  // handshake payloads
  // ---------------------------------------------------------
  typedef struct packed {
    md_op_e            op;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
  } md_cmd_t;                  // 35 bits

  typedef struct packed {
    logic [data_w-1:0] q_word;
    logic [data_w-1:0] a_word;
  } md_rsp_t;                  // 32 bits

endpackage

//--- hw/alu_qreg.sv
`timescale 1ns/1ps
// alu q register
// 16-bit register beside the alu, every bit picks hold, f,
// its lower neighbour or its upper neighbour through its own 4:1 mux

module alu_qreg (
  input  logic                      aluclk,
  input  logic                      arst_n,
  input  alu_pkg::qsel_e            qsel,    // mux select, same order as the slice
  input  logic                      qli,     // link in for shift left
  input  logic [md_pkg::data_w-1:0] f,       // alu result
  output logic [md_pkg::data_w-1:0] q_word
);

  import alu_pkg::*;
  import md_pkg::*;

  logic [data_w-1:0] q_nxt;                 // mux outputs

  // ---------------------------------------------------------
  // per bit source mux
  // ---------------------------------------------------------
  for (genvar i = 0; i < data_w; i++) begin : g_bit
    logic lo_src;                           // seen on shift left
    logic hi_src;                           // seen on rotate right

    if (i == 0) begin : g_lo_end
      assign lo_src = qli;                  // link bit enters at the bottom
    end else begin : g_lo_mid
      assign lo_src = q_word[i-1];
    end

    if (i == data_w - 1) begin : g_hi_end
      assign hi_src = q_word[0];            // wraps round on rotate
    end else begin : g_hi_mid
      assign hi_src = q_word[i+1];
    end

    assign q_nxt[i] = (qsel == q_hold)   ? q_word[i] :
                      (qsel == q_load_f) ? f[i]      :
                      (qsel == q_shl)    ? lo_src    : hi_src;
  end

  // ---------------------------------------------------------
  // register
  // ---------------------------------------------------------
  always_ff @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      q_word <= '0;
    end else begin
      q_word <= q_nxt;
    end
  end

  // the sequencer must always drive a defined mode
  a_qsel_known: assert property (@(posedge aluclk) disable iff (!arst_n)
    !$isunknown(qsel))
    else $error("alu_qreg: qsel unknown");

endmodule

//--- hw/alu_arith.sv
`timescale 1ns/1ps
// alu arithmetic slice
// selects r and s, forms f as add, subtract or pass,
// and keeps the a accumulator that pairs with the q register

module alu_arith (
  input  logic                      aluclk,
  input  logic                      arst_n,
  input  alu_pkg::alu_ctl_t         ctl,      // from the sequencer
  input  logic [md_pkg::data_w-1:0] cmd_a,    // latched operand a
  input  logic [md_pkg::data_w-1:0] cmd_b,    // latched operand b
  input  logic [md_pkg::data_w-1:0] q_word,   // q register
  output logic [md_pkg::data_w-1:0] f,        // alu result
  output logic                      borrow,   // divide trial borrow
  output logic [md_pkg::data_w-1:0] a_word    // accumulator
);

  import alu_pkg::*;
  import md_pkg::*;

  logic              link;                    // bit shifted into a from q
  logic [data_w-1:0] r_op;
  logic [data_w-1:0] s_op;
  logic [data_w+1:0] trial;                   // {a, q msb} - b with a guard bit

  // ---------------------------------------------------------
  // operand select
  // ---------------------------------------------------------
  // divide shifts a and q as one 32-bit word, multiply only doubles a
  assign link = (ctl.fn == fn_sub) ? q_word[data_w-1] : 1'b0;

  always_comb begin
    case (ctl.r_sel)
      r_cmd_a: r_op = cmd_a;
      r_a_shl: r_op = {a_word[data_w-2:0], link};
      default: r_op = '0;                     // r_zero
    endcase
  end

  assign s_op = (ctl.s_sel == s_cmd_b) ? cmd_b : '0;

  // ---------------------------------------------------------
  // function
  // ---------------------------------------------------------
  always_comb begin
    case (ctl.fn)
      fn_add:  f = r_op + s_op;
      fn_sub:  f = r_op - s_op;
      default: f = r_op;                      // fn_pass_r
    endcase
  end

  // trial subtract of a divide step, taken straight from the registers
  // so the sequencer can pick load_f or load_r in the same cycle
  // the a msb that leaves the word counts, so divisors above 0x8000 work
  assign trial  = {1'b0, a_word, q_word[data_w-1]} - {2'b00, cmd_b};
  assign borrow = trial[data_w+1];            // negative result

  // ---------------------------------------------------------
  // a register
  // ---------------------------------------------------------
  always_ff @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      a_word <= '0;
    end else begin
      case (ctl.asel)
        a_clear:  a_word <= '0;
        a_load_f: a_word <= f;
        a_load_r: a_word <= r_op;             // shifted a, trial dropped
        default:  a_word <= a_word;           // a_hold
      endcase
    end
  end

  // ---------------------------------------------------------
  // checks
  // ---------------------------------------------------------
  a_fn_known: assert property (@(posedge aluclk) disable iff (!arst_n)
    !$isunknown(ctl.fn))
    else $error("alu_arith: ctl.fn unknown");

endmodule

//--- hw/md_seq.sv
`timescale 1ns/1ps
// multiply/divide sequencer
// four-phase req/ack slave, latches the command and steps the alu and
// q register through the load cycle and 0 to 16 step cycles

module md_seq (
  input  logic                      aluclk,
  input  logic                      arst_n,
  input  logic                      cmd_req,
  input  md_pkg::md_cmd_t           cmd,
  output logic                      cmd_ack,
  output md_pkg::md_rsp_t           rsp,
  output alu_pkg::alu_ctl_t         ctl,
  output logic [md_pkg::data_w-1:0] cmd_a,
  output logic [md_pkg::data_w-1:0] cmd_b,
  input  logic [md_pkg::data_w-1:0] a_word,
  input  logic [md_pkg::data_w-1:0] q_word,
  input  logic                      borrow    // divide trial borrow
);

  import alu_pkg::*;
  import md_pkg::*;

  localparam int unsigned cnt_w = $clog2(data_w);

  typedef enum logic [1:0] {
    st_idle,                                  // wait for req
    st_load,                                  // clear a, load q through f
    st_step,                                  // one shift or rotate per cycle
    st_done                                   // ack high until req drops
  } state_e;

  state_e           state;
  state_e           state_nxt;
  logic [cnt_w-1:0] cnt;                      // steps left after this one
  logic [cnt_w-1:0] cnt_nxt;
  md_cmd_t          cmd_q;                    // command held for the whole run
  logic             no_steps;                 // result ready after load

  // ---------------------------------------------------------
  // command latch and control registers
  // ---------------------------------------------------------
  always_ff @(posedge aluclk) begin
    if (state == st_idle && cmd_req) begin
      cmd_q <= cmd;                           // taken once per handshake
    end
  end

  always_ff @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

  assign no_steps = (cmd_q.op == op_add) || (cmd_q.op == op_sub) ||
                    (cmd_q.op == op_ror && cmd_q.b[cnt_w-1:0] == '0);

  // ---------------------------------------------------------
  // next state
  // ---------------------------------------------------------
  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt;
    case (state)
      st_idle: begin
        if (cmd_req) begin
          state_nxt = st_load;
        end
      end
      st_load: begin
        if (no_steps) begin
          state_nxt = st_done;                // add, sub, ror by 0
        end else begin
          state_nxt = st_step;
          cnt_nxt   = (cmd_q.op == op_ror) ? cmd_q.b[cnt_w-1:0] - 1'b1 : cnt_w'(data_w - 1);
        end
      end
      st_step: begin
        if (cnt == '0) begin
          state_nxt = st_done;                // ack in the next cycle
        end else begin
          cnt_nxt = cnt - 1'b1;
        end
      end
      default: begin                          // st_done
        if (!cmd_req) begin
          state_nxt = st_idle;
        end
      end
    endcase
  end

  // ---------------------------------------------------------
  // alu control word
  // ---------------------------------------------------------
  always_comb begin
    ctl = '{fn: fn_pass_r, r_sel: r_zero, s_sel: s_zero,
            qsel: q_hold, asel: a_hold, qli: 1'b0};  // idle and done hold both
    case (state)
      st_load: begin
        ctl.r_sel = r_cmd_a;
        ctl.qsel  = q_load_f;
        ctl.asel  = a_clear;
        case (cmd_q.op)
          op_add: begin
            ctl.fn    = fn_add;
            ctl.s_sel = s_cmd_b;
          end
          op_sub: begin
            ctl.fn    = fn_sub;
            ctl.s_sel = s_cmd_b;
          end
          default: ctl.fn = fn_pass_r;        // q seeded with a
        endcase
      end
      st_step: begin
        case (cmd_q.op)
          op_mul: begin
            ctl.fn    = fn_add;               // a = 2a + q msb * b
            ctl.r_sel = r_a_shl;
            ctl.s_sel = q_word[data_w-1] ? s_cmd_b : s_zero;
            ctl.asel  = a_load_f;
            ctl.qsel  = q_shl;                // next multiplier bit to the top
          end
          op_div: begin
            ctl.fn    = fn_sub;               // trial subtract of b
            ctl.r_sel = r_a_shl;
            ctl.s_sel = s_cmd_b;
            ctl.asel  = borrow ? a_load_r : a_load_f;
            ctl.qli   = ~borrow;              // quotient bit
            ctl.qsel  = q_shl;
          end
          default: ctl.qsel = q_ror;          // ror, a untouched
        endcase
      end
      default: ;
    endcase
  end

  // ---------------------------------------------------------
  // handshake side
  // ---------------------------------------------------------
  assign cmd_a   = cmd_q.a;
  assign cmd_b   = cmd_q.b;
  assign cmd_ack = (state == st_done);
  assign rsp     = '{q_word: q_word, a_word: a_word};  // final once ack is up

  a_ack_after_req: assert property (@(posedge aluclk) disable iff (!arst_n)
    $rose(cmd_ack) |-> $past(cmd_req))
    else $error("md_seq: ack rose without a request");

  // back-pressure keeps ack and the result still
  a_ack_held: assert property (@(posedge aluclk) disable iff (!arst_n)
    (cmd_ack && cmd_req) |=> (cmd_ack && $stable(rsp)))
    else $error("md_seq: ack or rsp moved while req was high");

endmodule

//--- hw/md_top.sv
`timescale 1ns/1ps
// multiply/divide unit top
// sequencer, arithmetic slice and q register behind one req/ack port

module md_top (
  input  logic            aluclk,
  input  logic            arst_n,
  input  logic            cmd_req,   // four-phase request
  input  md_pkg::md_cmd_t cmd,       // stable while req is high
  output logic            cmd_ack,
  output md_pkg::md_rsp_t rsp        // valid while ack is high
);

  import alu_pkg::*;
  import md_pkg::*;

  alu_ctl_t          ctl;            // per cycle alu control
  logic [data_w-1:0] cmd_a;          // latched operands
  logic [data_w-1:0] cmd_b;
  logic [data_w-1:0] f;              // alu result into q
  logic [data_w-1:0] a_word;
  logic [data_w-1:0] q_word;
  logic              borrow;

  // ---------------------------------------------------------
  // sequencer
  // ---------------------------------------------------------
  md_seq i_seq (
    .aluclk  (aluclk),
    .arst_n  (arst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rsp     (rsp),
    .ctl     (ctl),
    .cmd_a   (cmd_a),
    .cmd_b   (cmd_b),
    .a_word  (a_word),
    .q_word  (q_word),
    .borrow  (borrow)
  );

  // ---------------------------------------------------------
  // datapath
  // ---------------------------------------------------------
  alu_arith i_arith (
    .aluclk (aluclk),
    .arst_n (arst_n),
    .ctl    (ctl),
    .cmd_a  (cmd_a),
    .cmd_b  (cmd_b),
    .q_word (q_word),
    .f      (f),
    .borrow (borrow),
    .a_word (a_word)
  );

  alu_qreg i_qreg (
    .aluclk (aluclk),
    .arst_n (arst_n),
    .qsel   (ctl.qsel),
    .qli    (ctl.qli),
    .f      (f),
    .q_word (q_word)
  );

endmodule

//--- test/md_check.sv
`timescale 1ns/1ps
// result checker for the multiply/divide unit
// watches the req/ack port, predicts every response from its command
// and guards the four-phase rules under back-pressure

module md_check (
  input  logic            aluclk,
  input  logic            arst_n,
  input  logic            cmd_req,
  input  md_pkg::md_cmd_t cmd,
  input  logic            cmd_ack,
  input  md_pkg::md_rsp_t rsp,
  output int              n_results,   // responses compared
  output int              n_errors
);

  import md_pkg::*;

  logic    ack_q;                      // values seen at the previous edge
  logic    req_q;
  md_rsp_t held;                       // response taken at the ack rise
  md_rsp_t exp_rsp;

  initial begin
    n_results = 0;
    n_errors  = 0;
    ack_q     = 1'b0;
    req_q     = 1'b0;
    held      = '0;
  end

  // ---------------------------------------------------------
  // reference model, straight from the result rules
  // ---------------------------------------------------------
  function automatic md_rsp_t expected_rsp(input md_cmd_t c);
    md_rsp_t     r;
    logic [31:0] wide;                 // product or doubled word for ror
    r = '0;
    case (c.op)
      op_add: r.q_word = c.a + c.b;   // wraps mod 2^16
      op_sub: r.q_word = c.a - c.b;
      op_mul: begin
        wide     = c.a * c.b;
        r.a_word = wide[15:0];         // low half only
      end
      op_div: begin
        if (c.b == '0) begin
          r.q_word = '1;               // divide by zero
          r.a_word = c.a;
        end else begin
          r.q_word = c.a / c.b;
          r.a_word = c.a % c.b;
        end
      end
      op_ror: begin
        wide     = {c.a, c.a} >> c.b[3:0];
        r.q_word = wide[15:0];
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic compare_word(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  // ---------------------------------------------------------
  // sampled on the rising edge, where inputs and registers are settled
  // ---------------------------------------------------------
  always @(posedge aluclk) begin
    if (!arst_n) begin
      if (cmd_ack !== 1'b0) begin
        $display("error at %0t: cmd_ack is high during reset", $time);
        n_errors++;
      end
      ack_q = 1'b0;
      req_q = 1'b0;
    end else begin
      if (cmd_ack && !ack_q) begin                   // new result
        if (!req_q) begin                            // req when ack went up
          $display("error at %0t: cmd_ack rose without a request", $time);
          n_errors++;
        end
        exp_rsp = expected_rsp(cmd);                 // cmd still held by req
        compare_word("rsp.q_word", rsp.q_word, exp_rsp.q_word);
        compare_word("rsp.a_word", rsp.a_word, exp_rsp.a_word);
        held = rsp;
        n_results++;
      end else if (ack_q && req_q) begin             // back-pressure
        if (!cmd_ack) begin
          $display("error at %0t: cmd_ack dropped while cmd_req was high", $time);
          n_errors++;
        end else begin
          compare_word("rsp.q_word (held)", rsp.q_word, held.q_word);
          compare_word("rsp.a_word (held)", rsp.a_word, held.a_word);
        end
      end else if (ack_q && !req_q && cmd_ack) begin
        $display("error at %0t: cmd_ack stayed high after cmd_req dropped", $time);
        n_errors++;
      end
      ack_q = cmd_ack;
      req_q = cmd_req;
    end
  end

endmodule

//--- test/md_tb.sv
`timescale 1ns/1ps
// testbench for the multiply/divide unit
// drives add, sub, mul, div and ror commands through the four-phase
// handshake on the falling edge, md_check compares every response

module md_tb;

  import md_pkg::*;

  localparam int rst_cycles   = 8;
  localparam int n_addsub     = 8;
  localparam int n_mul        = 40;
  localparam int n_div        = 40;
  localparam int n_ror        = 16;
  localparam int n_bp         = 12;
  localparam int n_cmds       = n_addsub + n_mul + n_div + n_ror + n_bp;
  localparam int limit_cycles = n_cmds * 20 + rst_cycles;  // watchdog

  logic        aluclk;
  logic        arst_n;
  logic        cmd_req;
  md_cmd_t     cmd;
  logic        cmd_ack;
  md_rsp_t     rsp;
  int          n_results;              // from md_check
  int          n_errors;
  int          n_sent;                 // handshakes completed
  int          err_mark;               // error count at test start
  int          extra_err;
  logic [31:0] lfsr = 32'ha629_9ae6;

  md_top i_dut (
    .aluclk  (aluclk),
    .arst_n  (arst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rsp     (rsp)
  );

  md_check i_check (
    .aluclk    (aluclk),
    .arst_n    (arst_n),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .cmd_ack   (cmd_ack),
    .rsp       (rsp),
    .n_results (n_results),
    .n_errors  (n_errors)
  );

  initial begin
    aluclk = 1'b0;
    forever #50 aluclk = ~aluclk;      // 100 ns period
  end

  // ---------------------------------------------------------
  // helpers
  // ---------------------------------------------------------
  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[14:0], fb};
    end
    return v;
  endfunction

  // one four-phase handshake, called and left on a falling edge
  task automatic send_cmd(input md_op_e op, input logic [data_w-1:0] a,
                          input logic [data_w-1:0] b, input int hold);
    cmd.op  = op;
    cmd.a   = a;
    cmd.b   = b;
    cmd_req = 1'b1;
    @(negedge aluclk);
    while (!cmd_ack) @(negedge aluclk);
    repeat (hold) @(negedge aluclk);   // extra cycles of back-pressure
    cmd_req = 1'b0;
    @(negedge aluclk);
    while (cmd_ack) @(negedge aluclk);
    n_sent++;
  endtask

  task automatic report_test(input string name, input int n);
    $display("test %s: %0d commands, %0d errors", name, n, n_errors - err_mark);
    err_mark = n_errors;
  endtask

  // ---------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------
  initial begin
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    md_op_e            op;
    int                hold;
    arst_n = 1'b0;
    cmd_req = 1'b0;
    cmd = '0;
    n_sent = 0;
    err_mark = 0;
    extra_err = 0;
    repeat (rst_cycles) @(posedge aluclk);
    @(negedge aluclk);
    arst_n = 1'b1;
    @(negedge aluclk);

    send_cmd(op_add, 16'h0001, 16'h0002, 0);
    send_cmd(op_add, 16'hffff, 16'h0001, 0);   // wraps to 0
    send_cmd(op_add, 16'h8000, 16'h8000, 0);
    send_cmd(op_sub, 16'h0005, 16'h0003, 0);
    send_cmd(op_sub, 16'h0000, 16'h0001, 0);   // wraps to ffff
    send_cmd(op_sub, 16'h1234, 16'h1234, 0);
    send_cmd(op_add, rand_bits(16), rand_bits(16), 0);
    send_cmd(op_sub, rand_bits(16), rand_bits(16), 0);
    report_test("1 reset, add and sub", n_addsub);

    for (int i = 0; i < n_mul; i++) begin
      a = rand_bits(16);
      b = rand_bits(16);
      send_cmd(op_mul, a, b, 0);
    end
    report_test("2 multiply", n_mul);

    for (int i = 0; i < n_div; i++) begin
      a = rand_bits(16);
      if (i % 10 == 0) b = '0;                  // divide by zero
      else if (i % 3 == 0) b = rand_bits(4);     // small divisors
      else b = rand_bits(16);
      send_cmd(op_div, a, b, 0);
    end
    report_test("3 divide", n_div);

    for (int i = 0; i < n_ror; i++) begin
      a = rand_bits(16);
      b = (rand_bits(12) << 4) | 16'(i);       // upper bits ignored
      send_cmd(op_ror, a, b, 0);
    end
    report_test("4 rotate right", n_ror);

    for (int i = 0; i < n_bp; i++) begin
      op   = md_op_e'(3'(rand_bits(8) % 16'd5));
      a    = rand_bits(16);
      b    = rand_bits(16);
      hold = 1 + int'(rand_bits(2));
      send_cmd(op, a, b, hold);
    end
    report_test("5 back-pressure", n_bp);

    repeat (2) @(negedge aluclk);
    if (n_results != n_sent) begin
      $display("error: %0d commands sent but %0d results seen", n_sent, n_results);
      extra_err++;
    end
    $display("summary: %0d commands, %0d results checked, %0d errors",
             n_sent, n_results, n_errors + extra_err);
    if (n_errors + extra_err == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    repeat (limit_cycles) @(posedge aluclk);
    $display("timeout: the run did not finish in %0d cycles, the handshake hung",
             limit_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

//--- md_unit.f
hw/alu_pkg.sv
hw/md_pkg.sv
hw/alu_qreg.sv
hw/alu_arith.sv
hw/md_seq.sv
hw/md_top.sv
test/md_check.sv
test/md_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the md_unit testbench with verilator and run it
# exit status is 0 only when the run prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f md_unit.f --top-module md_tb -Mdir obj_dir \
  || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/Vmd_tb 2>&1)"
echo "$out"

grep -qx "sim passed" <<< "$out" && exit 0 || exit 1
